// File: common/conv_params.svh
// Build-time sizes for the conv stage; kernel side must stay 3 and pixel words stay Q15.16
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Pixels per image row
// Power of two or not, the row RAMs size themselves from this
`define CONV_IMG_WIDTH 8

// Side of the square kernel
`define CONV_KERNEL 3

// Output channels computed per window
`define CONV_CHANNELS 2

// Width of pixels, weights and biases
`define CONV_PIX_BITS 32

// Fraction bits of the fixed-point format
`define CONV_FRAC_BITS 16

// Clamp negative outputs to zero when set
`define CONV_RELU 1

`endif

// File: common/conv_pkg.sv
// Shared stream and data types; all sizes come from conv_params.svh at compile time
`include "conv_params.svh"

package conv_pkg;

    // Signed fixed-point pixel, also used for weights and biases
    typedef logic signed [`CONV_PIX_BITS-1:0] pixel_t;

    // One beat of the input pixel stream
    typedef struct packed {
        pixel_t data;
        // High on the final pixel of an image
        logic   last;
    } pix_beat_t;

    // Sliding window, indexed [row][col]
    // Row 0 is the oldest image row, col 0 the leftmost pixel
    typedef pixel_t [`CONV_KERNEL-1:0][`CONV_KERNEL-1:0] tap_window_t;

    // Kernel coefficients of one output channel, same layout as the window
    typedef pixel_t [`CONV_KERNEL-1:0][`CONV_KERNEL-1:0] channel_weights_t;

    // Coefficients of every output channel
    typedef channel_weights_t [`CONV_CHANNELS-1:0] kernel_weights_t;

    // One bias per output channel
    typedef pixel_t [`CONV_CHANNELS-1:0] channel_bias_t;

    // One output pixel per channel, all leave together
    typedef pixel_t [`CONV_CHANNELS-1:0] channel_result_t;

    // Channel index
    // One value past the last channel marks the end of a sweep
    typedef logic [$clog2(`CONV_CHANNELS + 1)-1:0] chan_idx_t;

endpackage

// File: line_buffer/line_ram.sv
// One image row of storage; read data appears one cycle after the address, no read-during-write bypass
module line_ram #(
    parameter int DEPTH     = 8,
    parameter int DATA_BITS = 32
) (
    input  logic                         clk,
    input  logic                         i_wr_en,
    input  logic [$clog2(DEPTH)-1:0]     i_wr_addr,
    input  logic [DATA_BITS-1:0]         i_wr_data,
    input  logic [$clog2(DEPTH)-1:0]     i_rd_addr,
    output logic [DATA_BITS-1:0]         o_rd_data
);

    // Storage array, no reset
    logic [DATA_BITS-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        // Registered read port
        o_rd_data <= mem[i_rd_addr];
        // Write port, independent address
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

endmodule

// File: line_buffer/line_buffer.sv
// Row-major pixel stream to 3x3 windows, valid mode only; input must end each image with a last pixel
`include "conv_params.svh"

module line_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  conv_pkg::pix_beat_t    i_pix,
    input  logic                   i_valid,
    output logic                   o_ready,
    output conv_pkg::tap_window_t  o_window,
    output logic                   o_valid,
    input  logic                   i_win_ready,
    output logic                   o_last
);
    import conv_pkg::*;

    localparam int WIDTH     = `CONV_IMG_WIDTH;
    localparam int KSIZE     = `CONV_KERNEL;
    // Newest window row comes straight from the input
    localparam int BUF_ROWS  = KSIZE - 1;
    localparam int ADDR_BITS = $clog2(WIDTH);
    localparam int SEL_BITS  = (BUF_ROWS > 1) ? $clog2(BUF_ROWS) : 1;

    // Row RAM currently being overwritten, it holds the oldest row
    logic [SEL_BITS-1:0]   row_sel_q;
    logic [ADDR_BITS-1:0]  wr_addr_q;
    // Column whose data sits on the RAM read ports
    logic [ADDR_BITS-1:0]  rd_col_q;
    logic [ADDR_BITS-1:0]  rd_addr;
    logic                  in_done_q;
    logic                  out_done_q;
    // Set once two full rows are buffered
    logic                  filled_q;
    logic                  win_valid_q;
    logic                  win_last_q;
    tap_window_t           taps_q;
    pixel_t [BUF_ROWS-1:0] ram_data;
    pixel_t [KSIZE-1:0]    new_col;
    logic                  wr_en;
    logic                  free;
    logic                  step;
    logic                  out_active;
    logic                  row_switch;
    logic                  last_taken;

    for (genvar i = 0; i < BUF_ROWS; i++) begin : g_row_ram
        // Only the selected row RAM takes the incoming pixel
        line_ram #(
            .DEPTH     (WIDTH),
            .DATA_BITS (`CONV_PIX_BITS)
        ) line_ram_i (
            .clk       (clk),
            .i_wr_en   (wr_en && (row_sel_q == SEL_BITS'(i))),
            .i_wr_addr (wr_addr_q),
            .i_wr_data (i_pix.data),
            .i_rd_addr (rd_addr),
            .o_rd_data (ram_data[i])
        );
    end

    // Window register can take a new column
    assign free       = !win_valid_q || i_win_ready;
    assign out_active = filled_q && !out_done_q;
    // Input and window sides advance together
    // Final window of an image blocks everything until taken
    assign step       = free && (i_valid || in_done_q) && !win_last_q;
    assign row_switch = in_done_q && (out_done_q || !filled_q);
    assign last_taken = win_valid_q && win_last_q && i_win_ready;
    assign wr_en      = step && !in_done_q;
    // Low during the row switch cycle and while the last window waits
    assign o_ready    = !in_done_q && free && !win_last_q;

    // Next column is fetched one cycle ahead, stalls re-read the same column
    assign rd_addr = row_switch ? '0 :
                     (step && out_active) ? rd_col_q + 1'b1 : rd_col_q;

    // Rotate RAM outputs so window row 0 is always the oldest row
    always_comb begin
        int src;
        for (int r = 0; r < BUF_ROWS; r++) begin
            src = r + int'(row_sel_q);
            if (src >= BUF_ROWS) begin
                src = src - BUF_ROWS;
            end
            new_col[r] = ram_data[src];
        end
        new_col[KSIZE-1] = i_pix.data;
    end

    always_ff @(posedge clk) begin
        // Consuming the last window restarts for the next image
        if (reset || last_taken) begin
            row_sel_q   <= '0;
            wr_addr_q   <= '0;
            rd_col_q    <= '0;
            in_done_q   <= 1'b0;
            out_done_q  <= 1'b0;
            filled_q    <= 1'b0;
            win_valid_q <= 1'b0;
            win_last_q  <= 1'b0;
        end else begin
            rd_col_q <= rd_addr;
            if (row_switch) begin
                in_done_q  <= 1'b0;
                out_done_q <= 1'b0;
                wr_addr_q  <= '0;
                if (row_sel_q == SEL_BITS'(BUF_ROWS - 1)) begin
                    row_sel_q <= '0;
                    filled_q  <= 1'b1;
                end else begin
                    row_sel_q <= row_sel_q + 1'b1;
                end
            end else if (step && !in_done_q) begin
                wr_addr_q <= wr_addr_q + 1'b1;
                in_done_q <= (wr_addr_q == ADDR_BITS'(WIDTH - 1));
            end
            if (step && out_active) begin
                out_done_q  <= (rd_col_q == ADDR_BITS'(WIDTH - 1));
                // First two columns of a row only prime the window
                win_valid_q <= (rd_col_q >= ADDR_BITS'(KSIZE - 1));
                win_last_q  <= i_pix.last;
            end else if (i_win_ready) begin
                win_valid_q <= 1'b0;
            end
        end
    end

    // Horizontal shift of the window, newest column enters on the right
    always_ff @(posedge clk) begin
        if (step && out_active) begin
            for (int r = 0; r < KSIZE; r++) begin
                for (int c = 0; c < KSIZE - 1; c++) begin
                    taps_q[r][c] <= taps_q[r][c+1];
                end
                taps_q[r][KSIZE-1] <= new_col[r];
            end
        end
    end

    assign o_window = taps_q;
    assign o_valid  = win_valid_q;
    assign o_last   = win_last_q;

endmodule

// File: src/channel_counter.sv
// Channel sweep sequencer, two cycles per channel; a start while a sweep runs is ignored
`include "conv_params.svh"

module channel_counter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_start,
    output conv_pkg::chan_idx_t  o_chan,
    output logic                 o_phase,
    output logic                 o_done
);
    import conv_pkg::*;

    // Index one past the last channel ends the sweep
    localparam chan_idx_t END_IDX = chan_idx_t'(`CONV_CHANNELS);

    chan_idx_t chan_q;
    logic      phase_q;
    logic      busy_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            chan_q  <= '0;
            phase_q <= 1'b0;
            busy_q  <= 1'b0;
        end else if (!busy_q) begin
            chan_q  <= '0;
            phase_q <= 1'b0;
            busy_q  <= i_start;
        end else if (chan_q == END_IDX) begin
            // Back to idle after the done cycle
            chan_q <= '0;
            busy_q <= 1'b0;
        end else begin
            // Phase 0 loads the MAC, phase 1 stores its result
            phase_q <= ~phase_q;
            if (phase_q) begin
                chan_q <= chan_q + 1'b1;
            end
        end
    end

    assign o_chan  = chan_q;
    assign o_phase = phase_q;
    assign o_done  = busy_q && (chan_q == END_IDX);

endmodule

// File: src/conv_control.sv
// Window capture and output handshake FSM; only one window is in the MAC stage at a time
module conv_control (
    input  logic clk,
    input  logic reset,
    input  logic i_win_valid,
    input  logic i_win_last,
    output logic o_win_ready,
    output logic o_capture,
    output logic o_start,
    input  logic i_done,
    output logic o_valid,
    output logic o_last,
    input  logic i_ready
);

    // IDLE waits for a window
    // COMPUTE runs the channel sweep
    // HOLD presents the result until taken
    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        HOLD
    } state_t;

    state_t state_q;
    // Last flag travels with the captured window
    logic   last_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            last_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_win_valid) begin
                        state_q <= COMPUTE;
                        last_q  <= i_win_last;
                    end
                end
                COMPUTE: begin
                    if (i_done) begin
                        state_q <= HOLD;
                    end
                end
                HOLD: begin
                    // Output consumed on this edge
                    if (i_ready) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Accept windows only when idle, so back-pressure reaches the line buffer
    assign o_win_ready = (state_q == IDLE);
    assign o_capture   = o_win_ready && i_win_valid;
    // Sweep starts on the capture edge
    assign o_start     = o_capture;
    assign o_valid     = (state_q == HOLD);
    assign o_last      = o_valid && last_q;

endmodule

// File: src/kernel_mac.sv
// Time-shared 3x3 MAC with per-channel result slots; sums wrap to 32 bits after the Q16 rescale
`include "conv_params.svh"

module kernel_mac (
    input  logic                        clk,
    input  logic                        i_capture,
    input  conv_pkg::tap_window_t       i_window,
    input  conv_pkg::kernel_weights_t   i_weights,
    input  conv_pkg::channel_bias_t     i_bias,
    input  conv_pkg::chan_idx_t         i_chan,
    input  logic                        i_phase,
    output conv_pkg::channel_result_t   o_result
);
    import conv_pkg::*;

    localparam int PIX_BITS   = `CONV_PIX_BITS;
    localparam int FRAC_BITS  = `CONV_FRAC_BITS;
    localparam int KSIZE      = `CONV_KERNEL;
    localparam int CHAN_COUNT = `CONV_CHANNELS;
    localparam bit RELU_ON    = (`CONV_RELU != 0);

    tap_window_t                  window_q;
    channel_weights_t             chan_w;
    logic signed [2*PIX_BITS-1:0] acc;
    pixel_t                       dsp_q;
    channel_result_t              slot_q;
    channel_result_t              pre_act;

    // Weights of the active channel, zero past the last one
    always_comb begin
        chan_w = '0;
        if (i_chan < chan_idx_t'(CHAN_COUNT)) begin
            chan_w = i_weights[i_chan];
        end
    end

    // Full-width sum of the nine products
    always_comb begin
        acc = '0;
        for (int r = 0; r < KSIZE; r++) begin
            for (int c = 0; c < KSIZE; c++) begin
                acc = acc + $signed(window_q[r][c]) * $signed(chan_w[r][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_capture) begin
            window_q <= i_window;
        end
        // Product stage register, drop fraction bits back to Q15.16
        dsp_q <= acc[FRAC_BITS +: PIX_BITS];
        // Second cycle of a channel stores the settled product sum
        if (i_phase && i_chan < chan_idx_t'(CHAN_COUNT)) begin
            slot_q[i_chan] <= dsp_q;
        end
    end

    // Bias add and optional ReLU on every slot
    always_comb begin
        for (int ch = 0; ch < CHAN_COUNT; ch++) begin
            pre_act[ch] = slot_q[ch] + i_bias[ch];
            if (RELU_ON && pre_act[ch][PIX_BITS-1]) begin
                o_result[ch] = '0;
            end else begin
                o_result[ch] = pre_act[ch];
            end
        end
    end

endmodule

// File: src/conv2d_top.sv
// Streaming 3x3 valid-mode convolution; weights and bias must stay constant while an image streams
module conv2d_top (
    input  logic                        clk,
    input  logic                        reset,
    // Pixel stream in
    input  conv_pkg::pix_beat_t         i_pix,
    input  logic                        i_valid,
    output logic                        o_ready,
    // Quasi-static coefficients
    input  conv_pkg::kernel_weights_t   i_weights,
    input  conv_pkg::channel_bias_t     i_bias,
    // Result stream out
    output conv_pkg::channel_result_t   o_result,
    output logic                        o_valid,
    input  logic                        i_ready,
    output logic                        o_last
);
    import conv_pkg::*;

    // Window stream between line buffer and control
    tap_window_t window;
    logic        win_valid;
    logic        win_ready;
    logic        win_last;
    // Sweep steering
    logic        capture;
    logic        start;
    logic        done;
    chan_idx_t   chan;
    logic        phase;

    line_buffer line_buffer_i (
        .clk         (clk),
        .reset       (reset),
        .i_pix       (i_pix),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .o_window    (window),
        .o_valid     (win_valid),
        .i_win_ready (win_ready),
        .o_last      (win_last)
    );

    conv_control conv_control_i (
        .clk         (clk),
        .reset       (reset),
        .i_win_valid (win_valid),
        .i_win_last  (win_last),
        .o_win_ready (win_ready),
        .o_capture   (capture),
        .o_start     (start),
        .i_done      (done),
        .o_valid     (o_valid),
        .o_last      (o_last),
        .i_ready     (i_ready)
    );

    channel_counter channel_counter_i (
        .clk     (clk),
        .reset   (reset),
        .i_start (start),
        .o_chan  (chan),
        .o_phase (phase),
        .o_done  (done)
    );

    kernel_mac kernel_mac_i (
        .clk       (clk),
        .i_capture (capture),
        .i_window  (window),
        .i_weights (i_weights),
        .i_bias    (i_bias),
        .i_chan    (chan),
        .i_phase   (phase),
        .o_result  (o_result)
    );

endmodule

// File: verif/conv2d_assertions.sv
// Handshake properties of conv2d_top, bound into the DUT; needs a simulator running concurrent assertions
`include "conv_params.svh"

module conv2d_assertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      i_pix_ready,
    input conv_pkg::channel_result_t i_result,
    input logic                      i_res_valid,
    input logic                      i_res_ready,
    input logic                      i_res_last,
    input logic                      i_capture,
    input logic                      i_win_valid,
    input logic                      i_win_ready,
    input conv_pkg::tap_window_t     i_window
);
    timeunit 1ns;
    timeprecision 100ps;

    // Two cycles per channel plus the hand-over into HOLD
    localparam int LATENCY = 2 * `CONV_CHANNELS + 1;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Stalled output holds value and last flag
    hold_result_a: assert property (@(posedge clk) disable iff (reset)
        i_res_valid && !i_res_ready |=> i_res_valid && $stable(i_result) && $stable(i_res_last))
        else begin
            fail_count++;
            $error("output changed while stalled");
        end

    // Window waits unchanged for the control
    hold_window_a: assert property (@(posedge clk) disable iff (reset)
        i_win_valid && !i_win_ready |=> i_win_valid && $stable(i_window))
        else begin
            fail_count++;
            $error("window changed before capture");
        end

    // Result valid rises a fixed count of cycles after the capture edge
    // Sampled values lag that edge by one tick
    latency_a: assert property (@(posedge clk) disable iff (reset)
        i_capture |-> ##(LATENCY + 1) $rose(i_res_valid))
        else begin
            fail_count++;
            $error("o_valid not raised %0d cycles after capture", LATENCY);
        end

    // Quiet outputs right after reset
    reset_state_a: assert property (@(posedge clk)
        reset |=> !i_res_valid && !i_res_last && !i_win_valid && i_pix_ready)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

endmodule

// File: verif/conv2d_tb.sv
// Self-checking testbench for conv2d_top; images are 8x6, coefficients change only between streams
`include "conv_params.svh"

module conv2d_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import conv_pkg::*;

    localparam int IMG_W       = `CONV_IMG_WIDTH;
    localparam int IMG_ROWS    = 6;
    localparam int KSIZE       = `CONV_KERNEL;
    localparam int CHANNELS    = `CONV_CHANNELS;
    localparam int FRAC_BITS   = `CONV_FRAC_BITS;
    localparam bit RELU_ON     = (`CONV_RELU != 0);
    localparam int OUT_PER_IMG = (IMG_ROWS - KSIZE + 1) * (IMG_W - KSIZE + 1);
    localparam int IMAGES      = 5;
    localparam int CLK_NS      = 20;
    // Gaps and stalls roughly halve throughput, factor 4 leaves margin
    localparam int WATCHDOG_NS = CLK_NS * (200 + IMAGES * 4 *
                                 (IMG_ROWS * (IMG_W + 1) + OUT_PER_IMG * (2 * CHANNELS + 3)));

    // One expected output transfer
    typedef struct packed {
        channel_result_t result;
        logic            last;
    } out_beat_t;

    logic            clk;
    logic            reset;
    pix_beat_t       pix;
    logic            pix_valid;
    logic            pix_ready;
    kernel_weights_t weights;
    channel_bias_t   bias;
    channel_result_t result;
    logic            res_valid;
    logic            res_ready;
    logic            res_last;

    logic [31:0] lfsr_state = 32'd82181;
    pix_beat_t   pix_q[$];
    out_beat_t   exp_q[$];
    pix_beat_t   pix_save[$];
    out_beat_t   exp_save[$];

    conv2d_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .i_pix     (pix),
        .i_valid   (pix_valid),
        .o_ready   (pix_ready),
        .i_weights (weights),
        .i_bias    (bias),
        .o_result  (result),
        .o_valid   (res_valid),
        .i_ready   (res_ready),
        .o_last    (res_last)
    );

    bind conv2d_top conv2d_assertions conv2d_assertions_i (
        .clk         (clk),
        .reset       (reset),
        .i_pix_ready (o_ready),
        .i_result    (o_result),
        .i_res_valid (o_valid),
        .i_res_ready (i_ready),
        .i_res_last  (o_last),
        .i_capture   (capture),
        .i_win_valid (win_valid),
        .i_win_ready (win_ready),
        .i_window    (window)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before all outputs arrived");
    end

    // Galois LFSR, one step per bit
    function automatic logic rand_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    // Sign-extended random value of the given width
    function automatic pixel_t rand_signed(int bits);
        logic [31:0] raw;
        raw = '0;
        for (int i = 0; i < bits; i++) begin
            raw = {raw[30:0], rand_bit()};
        end
        return pixel_t'($signed(raw << (32 - bits)) >>> (32 - bits));
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns, %s is %h, expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_beat(out_beat_t exp);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            check_value($sformatf("o_result[%0d]", ch), 64'(result[ch]), 64'(exp.result[ch]));
        end
        check_value("o_last", 64'(res_last), 64'(exp.last));
    endtask

    // Odd channels mirror even ones so each image has negative and positive sums
    task automatic set_coefficients();
        pixel_t w;
        pixel_t b;
        b = rand_signed(18);
        for (int r = 0; r < KSIZE; r++) begin
            for (int c = 0; c < KSIZE; c++) begin
                w = rand_signed(17);
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    weights[ch][r][c] = ch[0] ? -w : w;
                end
            end
        end
        for (int ch = 0; ch < CHANNELS; ch++) begin
            bias[ch] = ch[0] ? -b : b;
        end
    endtask

    // Random image into the pixel queue, reference convolution into the expected queue
    task automatic add_image();
        pixel_t    img [IMG_ROWS][IMG_W];
        longint    sum;
        pixel_t    pre;
        pix_beat_t pb;
        out_beat_t ob;
        int        neg_count;
        int        pos_count;
        neg_count = 0;
        pos_count = 0;
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                img[r][c] = rand_signed(20);
                pb.data = img[r][c];
                pb.last = (r == IMG_ROWS - 1) && (c == IMG_W - 1);
                pix_q.push_back(pb);
            end
        end
        for (int r = 0; r <= IMG_ROWS - KSIZE; r++) begin
            for (int c = 0; c <= IMG_W - KSIZE; c++) begin
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    sum = 0;
                    for (int kr = 0; kr < KSIZE; kr++) begin
                        for (int kc = 0; kc < KSIZE; kc++) begin
                            sum += longint'(img[r+kr][c+kc]) * longint'(weights[ch][kr][kc]);
                        end
                    end
                    // Back to Q15.16, then bias and ReLU
                    pre = pixel_t'(sum >>> FRAC_BITS) + bias[ch];
                    neg_count += (pre < 0) ? 1 : 0;
                    pos_count += (pre > 0) ? 1 : 0;
                    ob.result[ch] = (RELU_ON && pre < 0) ? '0 : pre;
                end
                ob.last = (r == IMG_ROWS - KSIZE) && (c == IMG_W - KSIZE);
                exp_q.push_back(ob);
            end
        end
        if (neg_count == 0 || pos_count == 0) begin
            fail_run("Stimulus image lacks either negative or positive sums");
        end
    endtask

    // Streams both queues dry, one decision per falling edge
    task automatic run_stream(input bit gaps, input bit stalls);
        bit        ready_seen;
        bit        holding;
        out_beat_t held;
        out_beat_t exp_beat;
        ready_seen = 1'b0;
        holding    = 1'b0;
        while (pix_q.size() != 0 || exp_q.size() != 0) begin
            @(negedge clk);
            // Input side, a beat stays up until taken
            if (pix_valid && ready_seen) begin
                void'(pix_q.pop_front());
                pix_valid = 1'b0;
            end
            if (!pix_valid && pix_q.size() != 0 && !(gaps && rand_bit())) begin
                pix       = pix_q[0];
                pix_valid = 1'b1;
            end
            ready_seen = pix_ready;
            // Output side, a stalled beat must not move
            if (holding) begin
                check_value("o_valid", 64'(res_valid), 64'd1);
                compare_beat(held);
            end
            res_ready = stalls ? rand_bit() : 1'b1;
            holding   = 1'b0;
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("An output arrived that the model did not expect");
                end else begin
                    exp_beat = exp_q.pop_front();
                    compare_beat(exp_beat);
                end
            end else if (res_valid) begin
                holding     = 1'b1;
                held.result = result;
                held.last   = res_last;
            end
        end
    endtask

    // No extra output after the last expected one
    task automatic check_quiet();
        repeat (10) begin
            @(negedge clk);
            check_value("o_valid", 64'(res_valid), 64'd0);
        end
    endtask

    initial begin
        reset     = 1'b1;
        pix       = '0;
        pix_valid = 1'b0;
        weights   = '0;
        bias      = '0;
        res_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Idle outputs before any pixel
        repeat (4) begin
            @(negedge clk);
            check_value("o_valid", 64'(res_valid), 64'd0);
            check_value("o_last", 64'(res_last), 64'd0);
            check_value("o_ready", 64'(pix_ready), 64'd1);
        end
        // One image at full rate
        set_coefficients();
        add_image();
        pix_save = pix_q;
        exp_save = exp_q;
        run_stream(1'b0, 1'b0);
        check_quiet();
        // Same image with random gaps and stalls
        pix_q = pix_save;
        exp_q = exp_save;
        run_stream(1'b1, 1'b1);
        check_quiet();
        // Three images back to back, new coefficients
        set_coefficients();
        repeat (3) add_image();
        run_stream(1'b1, 1'b1);
        check_quiet();
        if (dut_i.conv2d_assertions_i.fail_count != 0) begin
            $display("Handshake assertions failed %0d times", dut_i.conv2d_assertions_i.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failures");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+common
common/conv_pkg.sv
line_buffer/line_ram.sv
line_buffer/line_buffer.sv
src/channel_counter.sv
src/conv_control.sv
src/kernel_mac.sv
src/conv2d_top.sv
verif/conv2d_assertions.sv
verif/conv2d_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the conv2d testbench with Verilator 5, exit status 0 only on a passing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module conv2d_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vconv2d_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
